/* common/mem_sched_pkg.sv */
// Sizes and packed bundles shared by the memory request scheduler blocks and its testbench
package mem_sched_pkg;

    localparam int CORE_REQS     = 4;
    localparam int MEM_CHANNELS  = 2;
    localparam int MEM_BATCHES   = 2;
    localparam int BATCH_BITS    = 1;
    localparam int WORD_WIDTH    = 32;
    localparam int WORD_BYTES    = 4;
    localparam int ADDR_WIDTH    = 30;
    localparam int TAG_WIDTH     = 8;
    localparam int QUEUE_SIZE    = 4;
    localparam int SLOT_BITS     = 2;
    // Slot index on top, batch index in the low bits
    localparam int MEM_TAG_WIDTH = SLOT_BITS + BATCH_BITS;

    typedef struct packed {
        logic                                    rw;
        logic [CORE_REQS-1:0]                    mask;
        logic [CORE_REQS-1:0][WORD_BYTES-1:0]    byteen;
        logic [CORE_REQS-1:0][ADDR_WIDTH-1:0]    addr;
        logic [CORE_REQS-1:0][WORD_WIDTH-1:0]    data;
        logic [TAG_WIDTH-1:0]                    tag;
    } core_req_t;

    // Queue entry, core tag replaced by the read slot
    typedef struct packed {
        logic                                    rw;
        logic [CORE_REQS-1:0]                    mask;
        logic [CORE_REQS-1:0][WORD_BYTES-1:0]    byteen;
        logic [CORE_REQS-1:0][ADDR_WIDTH-1:0]    addr;
        logic [CORE_REQS-1:0][WORD_WIDTH-1:0]    data;
        logic [SLOT_BITS-1:0]                    slot;
    } queued_req_t;

    typedef struct packed {
        logic                                    rw;
        logic [MEM_CHANNELS-1:0]                 mask;
        logic [MEM_CHANNELS-1:0][WORD_BYTES-1:0] byteen;
        logic [MEM_CHANNELS-1:0][ADDR_WIDTH-1:0] addr;
        logic [MEM_CHANNELS-1:0][WORD_WIDTH-1:0] data;
        logic [MEM_TAG_WIDTH-1:0]                tag;
    } mem_req_t;

    typedef struct packed {
        logic [MEM_CHANNELS-1:0]                 mask;
        logic [MEM_CHANNELS-1:0][WORD_WIDTH-1:0] data;
        logic [MEM_TAG_WIDTH-1:0]                tag;
    } mem_rsp_t;

    typedef struct packed {
        logic [CORE_REQS-1:0]                    mask;
        logic [CORE_REQS-1:0][WORD_WIDTH-1:0]    data;
        logic [TAG_WIDTH-1:0]                    tag;
    } core_rsp_t;

endpackage

/* request/req_queue.sv */
// Core request FIFO; accepts a request when there is room and, for reads, a free slot
module req_queue (
    input  logic                               clk,
    input  logic                               reset,
    input  mem_sched_pkg::core_req_t           core_req,
    input  logic                               core_req_valid,
    output logic                               core_req_ready,
    input  logic [mem_sched_pkg::SLOT_BITS-1:0] alloc_slot,
    input  logic                               slots_full,
    output logic                               alloc,
    output mem_sched_pkg::queued_req_t         queued,
    output logic                               queued_valid,
    input  logic                               queued_ready,
    output logic                               queue_empty
);
    import mem_sched_pkg::*;

    queued_req_t          entries [QUEUE_SIZE];
    queued_req_t          entry_in;
    logic [SLOT_BITS-1:0] wr_ptr;
    logic [SLOT_BITS-1:0] rd_ptr;
    logic [SLOT_BITS:0]   count;
    logic                 full;
    logic                 push;
    logic                 pop;

    assign full           = (count == QUEUE_SIZE);
    assign core_req_ready = !full && (core_req.rw || !slots_full);
    assign push           = core_req_valid && core_req_ready;
    assign pop            = queued_valid && queued_ready;
    assign alloc          = push && !core_req.rw;

    assign queued_valid = (count != 0);
    assign queue_empty  = (count == 0);
    assign queued       = entries[rd_ptr];

    always_comb begin
        entry_in.rw     = core_req.rw;
        entry_in.mask   = core_req.mask;
        entry_in.byteen = core_req.byteen;
        entry_in.addr   = core_req.addr;
        entry_in.data   = core_req.data;
        // Writes never come back, so their slot field stays zero
        entry_in.slot   = core_req.rw ? '0 : alloc_slot;
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= entry_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* request/req_batcher.sv */
// Splits the head queue entry into two-lane memory batches and registers each memory request
module req_batcher (
    input  logic                       clk,
    input  logic                       reset,
    input  mem_sched_pkg::queued_req_t queued,
    input  logic                       queued_valid,
    output logic                       queued_ready,
    output mem_sched_pkg::mem_req_t    mem_req,
    output logic                       mem_req_valid,
    input  logic                       mem_req_ready
);
    import mem_sched_pkg::*;

    logic [BATCH_BITS-1:0]                   batch_idx;
    logic [BATCH_BITS-1:0]                   cur_batch;
    logic [BATCH_BITS-1:0]                   last_batch;
    logic [MEM_BATCHES-1:0][MEM_CHANNELS-1:0] batch_mask;
    logic                                    any_batch;
    logic                                    load_ok;
    logic                                    issue;
    mem_req_t                                mem_req_n;

    always_comb begin
        for (int b = 0; b < MEM_BATCHES; b++) begin
            batch_mask[b] = queued.mask[b*MEM_CHANNELS +: MEM_CHANNELS];
        end
    end

    assign any_batch = |queued.mask;

    // First non-empty batch at or after the counter, and the last non-empty one
    always_comb begin
        cur_batch  = batch_idx;
        last_batch = '0;
        for (int b = MEM_BATCHES - 1; b >= 0; b--) begin
            if (b >= batch_idx && |batch_mask[b]) begin
                cur_batch = BATCH_BITS'(b);
            end
        end
        for (int b = 0; b < MEM_BATCHES; b++) begin
            if (|batch_mask[b]) begin
                last_batch = BATCH_BITS'(b);
            end
        end
    end

    assign load_ok = !mem_req_valid || mem_req_ready;
    assign issue   = queued_valid && any_batch && load_ok;

    // Entry leaves once its last batch is loaded; an all-masked entry is dropped at once
    assign queued_ready = !any_batch || (load_ok && cur_batch == last_batch);

    always_comb begin
        mem_req_n.rw   = queued.rw;
        mem_req_n.mask = batch_mask[cur_batch];
        mem_req_n.tag  = {queued.slot, cur_batch};
        for (int c = 0; c < MEM_CHANNELS; c++) begin
            mem_req_n.byteen[c] = queued.byteen[cur_batch*MEM_CHANNELS + c];
            mem_req_n.addr[c]   = queued.addr[cur_batch*MEM_CHANNELS + c];
            mem_req_n.data[c]   = queued.data[cur_batch*MEM_CHANNELS + c];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            batch_idx     <= '0;
            mem_req_valid <= 1'b0;
        end else begin
            if (queued_valid && queued_ready) begin
                batch_idx <= '0;
            end else if (issue) begin
                batch_idx <= cur_batch + 1'b1;
            end
            if (load_ok) begin
                mem_req_valid <= issue;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            mem_req <= mem_req_n;
        end
    end

endmodule

/* response/rsp_assembler.sv */
// Collects out-of-order memory responses per slot and emits one full core response per read
module rsp_assembler (
    input  logic                                 clk,
    input  logic                                 reset,
    input  mem_sched_pkg::mem_rsp_t              mem_rsp,
    input  logic                                 mem_rsp_valid,
    output logic                                 mem_rsp_ready,
    output logic [mem_sched_pkg::SLOT_BITS-1:0]  lookup_slot,
    input  logic [mem_sched_pkg::TAG_WIDTH-1:0]  lookup_tag,
    input  logic [mem_sched_pkg::CORE_REQS-1:0]  lookup_mask,
    output mem_sched_pkg::core_rsp_t             core_rsp,
    output logic                                 core_rsp_valid,
    input  logic                                 core_rsp_ready,
    output logic                                 release_en,
    output logic [mem_sched_pkg::SLOT_BITS-1:0]  release_slot
);
    import mem_sched_pkg::*;

    logic [QUEUE_SIZE-1:0][CORE_REQS-1:0]     rcvd;
    logic [CORE_REQS-1:0][WORD_WIDTH-1:0]     store [QUEUE_SIZE];
    logic [CORE_REQS-1:0][WORD_WIDTH-1:0]     store_n;
    logic [CORE_REQS-1:0]                     cur_mask;
    logic [CORE_REQS-1:0]                     rcvd_n;
    logic [SLOT_BITS-1:0]                     rsp_slot;
    logic [BATCH_BITS-1:0]                    rsp_batch;
    logic [SLOT_BITS-1:0]                     out_slot;
    logic                                     complete;
    logic                                     load_ok;
    logic                                     mem_rsp_fire;

    assign rsp_slot    = mem_rsp.tag[MEM_TAG_WIDTH-1 -: SLOT_BITS];
    assign rsp_batch   = mem_rsp.tag[BATCH_BITS-1:0];
    assign lookup_slot = rsp_slot;

    // Place channel data into the lanes of this batch
    always_comb begin
        store_n  = store[rsp_slot];
        cur_mask = '0;
        for (int r = 0; r < CORE_REQS; r++) begin
            if (r / MEM_CHANNELS == rsp_batch && mem_rsp.mask[r % MEM_CHANNELS]) begin
                cur_mask[r] = 1'b1;
                store_n[r]  = mem_rsp.data[r % MEM_CHANNELS];
            end
        end
    end

    assign rcvd_n   = rcvd[rsp_slot] | cur_mask;
    assign complete = (rcvd_n == lookup_mask);

    // Partial responses need no output slot, but the register must be free to take any response
    assign load_ok       = !core_rsp_valid || core_rsp_ready;
    assign mem_rsp_ready = load_ok;
    assign mem_rsp_fire  = mem_rsp_valid && load_ok;

    assign release_en   = core_rsp_valid && core_rsp_ready;
    assign release_slot = out_slot;

    always_ff @(posedge clk) begin
        if (mem_rsp_fire) begin
            store[rsp_slot] <= store_n;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rcvd           <= '0;
            core_rsp_valid <= 1'b0;
        end else begin
            if (mem_rsp_fire) begin
                rcvd[rsp_slot] <= complete ? '0 : rcvd_n;
            end
            if (load_ok) begin
                core_rsp_valid <= mem_rsp_fire && complete;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rsp_fire && complete) begin
            core_rsp.mask <= lookup_mask;
            core_rsp.data <= store_n;
            core_rsp.tag  <= lookup_tag;
            out_slot      <= rsp_slot;
        end
    end

endmodule

/* design/slot_table.sv */
// Read slot allocator holding each pending read's core tag and lane mask
module slot_table (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                alloc,
    input  logic [mem_sched_pkg::TAG_WIDTH-1:0] alloc_tag,
    input  logic [mem_sched_pkg::CORE_REQS-1:0] alloc_mask,
    output logic [mem_sched_pkg::SLOT_BITS-1:0] alloc_slot,
    output logic                                slots_full,
    input  logic [mem_sched_pkg::SLOT_BITS-1:0] lookup_slot,
    output logic [mem_sched_pkg::TAG_WIDTH-1:0] lookup_tag,
    output logic [mem_sched_pkg::CORE_REQS-1:0] lookup_mask,
    input  logic                                release_en,
    input  logic [mem_sched_pkg::SLOT_BITS-1:0] release_slot,
    input  logic                                queue_empty,
    output logic                                core_req_empty
);
    import mem_sched_pkg::*;

    logic [QUEUE_SIZE-1:0] used;
    logic [TAG_WIDTH-1:0]  tags  [QUEUE_SIZE];
    logic [CORE_REQS-1:0]  masks [QUEUE_SIZE];

    // Lowest free slot wins
    always_comb begin
        alloc_slot = '0;
        for (int i = QUEUE_SIZE - 1; i >= 0; i--) begin
            if (!used[i]) begin
                alloc_slot = SLOT_BITS'(i);
            end
        end
    end

    assign slots_full     = &used;
    assign core_req_empty = !(|used) && queue_empty;
    assign lookup_tag     = tags[lookup_slot];
    assign lookup_mask    = masks[lookup_slot];

    always_ff @(posedge clk) begin
        if (alloc) begin
            tags[alloc_slot]  <= alloc_tag;
            masks[alloc_slot] <= alloc_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            used <= '0;
        end else begin
            if (alloc) begin
                used[alloc_slot] <= 1'b1;
            end
            if (release_en) begin
                used[release_slot] <= 1'b0;
            end
        end
    end

endmodule

/* design/mem_scheduler.sv */
// Memory request scheduler top; instantiate with the core and memory valid/ready channels
module mem_scheduler (
    input  logic                      clk,
    input  logic                      reset,
    input  mem_sched_pkg::core_req_t  core_req,
    input  logic                      core_req_valid,
    output logic                      core_req_ready,
    output logic                      core_req_empty,
    output mem_sched_pkg::core_rsp_t  core_rsp,
    output logic                      core_rsp_valid,
    input  logic                      core_rsp_ready,
    output mem_sched_pkg::mem_req_t   mem_req,
    output logic                      mem_req_valid,
    input  logic                      mem_req_ready,
    input  mem_sched_pkg::mem_rsp_t   mem_rsp,
    input  logic                      mem_rsp_valid,
    output logic                      mem_rsp_ready
);
    import mem_sched_pkg::*;

    queued_req_t          queued;
    logic                 queued_valid;
    logic                 queued_ready;
    logic                 queue_empty;
    logic                 alloc;
    logic [SLOT_BITS-1:0] alloc_slot;
    logic                 slots_full;
    logic [SLOT_BITS-1:0] lookup_slot;
    logic [TAG_WIDTH-1:0] lookup_tag;
    logic [CORE_REQS-1:0] lookup_mask;
    logic                 release_en;
    logic [SLOT_BITS-1:0] release_slot;

    req_queue u_req_queue (
        .clk            (clk),
        .reset          (reset),
        .core_req       (core_req),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .alloc_slot     (alloc_slot),
        .slots_full     (slots_full),
        .alloc          (alloc),
        .queued         (queued),
        .queued_valid   (queued_valid),
        .queued_ready   (queued_ready),
        .queue_empty    (queue_empty)
    );

    req_batcher u_req_batcher (
        .clk           (clk),
        .reset         (reset),
        .queued        (queued),
        .queued_valid  (queued_valid),
        .queued_ready  (queued_ready),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready)
    );

    // Tag and mask are captured straight from the accepted request
    slot_table u_slot_table (
        .clk            (clk),
        .reset          (reset),
        .alloc          (alloc),
        .alloc_tag      (core_req.tag),
        .alloc_mask     (core_req.mask),
        .alloc_slot     (alloc_slot),
        .slots_full     (slots_full),
        .lookup_slot    (lookup_slot),
        .lookup_tag     (lookup_tag),
        .lookup_mask    (lookup_mask),
        .release_en     (release_en),
        .release_slot   (release_slot),
        .queue_empty    (queue_empty),
        .core_req_empty (core_req_empty)
    );

    rsp_assembler u_rsp_assembler (
        .clk            (clk),
        .reset          (reset),
        .mem_rsp        (mem_rsp),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_ready  (mem_rsp_ready),
        .lookup_slot    (lookup_slot),
        .lookup_tag     (lookup_tag),
        .lookup_mask    (lookup_mask),
        .core_rsp       (core_rsp),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_ready (core_rsp_ready),
        .release_en     (release_en),
        .release_slot   (release_slot)
    );

endmodule

/* tests/mem_sched_checker.sv */
// Watches the scheduler ports, predicts memory and core traffic from accepted requests, counts errors
module mem_sched_checker (
    input  logic                     clk,
    input  logic                     reset,
    input  mem_sched_pkg::core_req_t core_req,
    input  logic                     core_req_valid,
    input  logic                     core_req_ready,
    input  logic                     core_req_empty,
    input  mem_sched_pkg::core_rsp_t core_rsp,
    input  logic                     core_rsp_valid,
    input  logic                     core_rsp_ready,
    input  mem_sched_pkg::mem_req_t  mem_req,
    input  logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    input  logic                     mem_rsp_ready,
    output int                       error_count,
    output int                       reads_pending,
    output int                       mem_reqs_pending
);
    timeunit 1ns;
    timeprecision 1ns;
    import mem_sched_pkg::*;

    mem_req_t    exp_mem [$];
    core_rsp_t   exp_rsp [$];
    logic [31:0] shadow [64];
    logic [63:0] written;
    core_rsp_t   held_rsp;
    logic        rsp_held;
    logic        check_idle;

    initial error_count = 0;

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %0h expected %0h", name, got, exp);
            error_count++;
        end
    endtask

    // Unwritten words read back as the address pattern
    function automatic logic [31:0] expected_word(input logic [ADDR_WIDTH-1:0] addr);
        return written[addr[5:0]] ? shadow[addr[5:0]] : {2'b00, addr} ^ 32'hA5A5_0000;
    endfunction

    task automatic store_write(input logic [ADDR_WIDTH-1:0] addr, input logic [3:0] be,
                               input logic [31:0] data);
        logic [31:0] word;
        word = expected_word(addr);
        for (int k = 0; k < WORD_BYTES; k++) begin
            if (be[k]) begin
                word[8*k +: 8] = data[8*k +: 8];
            end
        end
        shadow[addr[5:0]]  = word;
        written[addr[5:0]] = 1'b1;
    endtask

    task automatic predict_request(input core_req_t req);
        mem_req_t  m;
        core_rsp_t r;
        for (int b = 0; b < MEM_BATCHES; b++) begin
            if (req.mask[b*MEM_CHANNELS +: MEM_CHANNELS] != '0) begin
                m.rw   = req.rw;
                m.mask = req.mask[b*MEM_CHANNELS +: MEM_CHANNELS];
                m.tag  = {SLOT_BITS'(0), BATCH_BITS'(b)};
                for (int c = 0; c < MEM_CHANNELS; c++) begin
                    m.byteen[c] = req.byteen[b*MEM_CHANNELS + c];
                    m.addr[c]   = req.addr[b*MEM_CHANNELS + c];
                    m.data[c]   = req.data[b*MEM_CHANNELS + c];
                end
                exp_mem.push_back(m);
            end
        end
        r.mask = req.mask;
        r.tag  = req.tag;
        for (int l = 0; l < CORE_REQS; l++) begin
            r.data[l] = (req.mask[l] && !req.rw) ? expected_word(req.addr[l]) : '0;
            if (req.mask[l] && req.rw) begin
                store_write(req.addr[l], req.byteen[l], req.data[l]);
            end
        end
        if (!req.rw) begin
            exp_rsp.push_back(r);
        end
    endtask

    task automatic check_mem_req(input mem_req_t got);
        mem_req_t e;
        if (exp_mem.size() == 0) begin
            $display("Memory request with tag %0h was not expected", got.tag);
            error_count++;
        end else begin
            e = exp_mem.pop_front();
            compare_value("mem_req.rw", got.rw, e.rw);
            compare_value("mem_req.mask", got.mask, e.mask);
            compare_value("mem_req.tag batch", got.tag[BATCH_BITS-1:0], e.tag[BATCH_BITS-1:0]);
            for (int c = 0; c < MEM_CHANNELS; c++) begin
                if (e.mask[c]) begin
                    compare_value($sformatf("mem_req.addr[%0d]", c), got.addr[c], e.addr[c]);
                    compare_value($sformatf("mem_req.byteen[%0d]", c), got.byteen[c], e.byteen[c]);
                    if (e.rw) begin
                        compare_value($sformatf("mem_req.data[%0d]", c), got.data[c], e.data[c]);
                    end
                end
            end
        end
    endtask

    task automatic check_core_rsp(input core_rsp_t got);
        int found;
        found = -1;
        for (int i = 0; i < exp_rsp.size(); i++) begin
            if (exp_rsp[i].tag == got.tag) begin
                found = i;
            end
        end
        if (found < 0) begin
            $display("Core response with tag %0h matches no pending read", got.tag);
            error_count++;
        end else begin
            compare_value("core_rsp.mask", got.mask, exp_rsp[found].mask);
            for (int l = 0; l < CORE_REQS; l++) begin
                if (exp_rsp[found].mask[l]) begin
                    compare_value($sformatf("core_rsp.data[%0d]", l), got.data[l],
                                  exp_rsp[found].data[l]);
                end
            end
            exp_rsp.delete(found);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            exp_mem.delete();
            exp_rsp.delete();
            written = '0;
            rsp_held   <= 1'b0;
            check_idle <= 1'b1;
        end else begin
            if (check_idle) begin
                compare_value("mem_req_valid", mem_req_valid, 1'b0);
                compare_value("core_rsp_valid", core_rsp_valid, 1'b0);
                compare_value("core_req_empty", core_req_empty, 1'b1);
                compare_value("mem_rsp_ready", mem_rsp_ready, 1'b1);
                check_idle <= 1'b0;
            end
            // A stalled response must stay put
            if (rsp_held) begin
                compare_value("core_rsp_valid", core_rsp_valid, 1'b1);
                if (core_rsp !== held_rsp) begin
                    $display("Mismatch core_rsp: got %0h expected %0h", core_rsp, held_rsp);
                    error_count++;
                end
            end
            // Memory responses wait while a core response is held
            if (core_rsp_valid && !core_rsp_ready) begin
                compare_value("mem_rsp_ready", mem_rsp_ready, 1'b0);
            end
            if (core_req_valid && core_req_ready) begin
                if (!core_req.rw && exp_rsp.size() == QUEUE_SIZE) begin
                    $display("Read with tag %0h accepted while all slots were in use",
                             core_req.tag);
                    error_count++;
                end
                predict_request(core_req);
            end
            if (mem_req_valid && mem_req_ready) begin
                check_mem_req(mem_req);
            end
            if (core_rsp_valid && core_rsp_ready) begin
                check_core_rsp(core_rsp);
            end
            rsp_held <= core_rsp_valid && !core_rsp_ready;
            held_rsp <= core_rsp;
        end
        reads_pending    <= exp_rsp.size();
        mem_reqs_pending <= exp_mem.size();
    end

endmodule

/* tests/tb_mem_scheduler.sv */
// Testbench top for the memory scheduler; applies a request table against a random-latency memory
module tb_mem_scheduler;
    timeunit 1ns;
    timeprecision 1ns;
    import mem_sched_pkg::*;

    localparam logic [ADDR_WIDTH-1:0] BASE_ADDR  = 30'h0123_4000;
    localparam int                    WAIT_LIMIT = 2000;
    localparam int                    NUM_ROWS   = 12;

    typedef struct packed {
        logic        rw;
        logic [3:0]  mask;
        logic [15:0] byteen;
        logic [5:0]  offset;
        logic [31:0] data;
        logic [7:0]  tag;
    } stim_t;

    logic        clk;
    logic        reset;
    core_req_t   core_req;
    logic        core_req_valid;
    logic        core_req_ready;
    logic        core_req_empty;
    core_rsp_t   core_rsp;
    logic        core_rsp_valid;
    logic        core_rsp_ready;
    mem_req_t    mem_req;
    logic        mem_req_valid;
    logic        mem_req_ready;
    mem_rsp_t    mem_rsp;
    logic        mem_rsp_valid;
    logic        mem_rsp_ready;
    stim_t       rows [NUM_ROWS];
    mem_rsp_t    pending [$];
    logic [31:0] mem_words [64];
    logic [63:0] mem_written;
    int          seed = 2839;
    int          gap;
    int          pick;
    int          timeouts;
    int          error_count;
    int          reads_pending;
    int          mem_reqs_pending;

    mem_scheduler UUT (
        .clk(clk), .reset(reset),
        .core_req(core_req), .core_req_valid(core_req_valid), .core_req_ready(core_req_ready),
        .core_req_empty(core_req_empty),
        .core_rsp(core_rsp), .core_rsp_valid(core_rsp_valid), .core_rsp_ready(core_rsp_ready),
        .mem_req(mem_req), .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_rsp(mem_rsp), .mem_rsp_valid(mem_rsp_valid), .mem_rsp_ready(mem_rsp_ready)
    );

    mem_sched_checker u_checker (
        .clk(clk), .reset(reset),
        .core_req(core_req), .core_req_valid(core_req_valid), .core_req_ready(core_req_ready),
        .core_req_empty(core_req_empty),
        .core_rsp(core_rsp), .core_rsp_valid(core_rsp_valid), .core_rsp_ready(core_rsp_ready),
        .mem_req(mem_req), .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_rsp_ready(mem_rsp_ready),
        .error_count(error_count), .reads_pending(reads_pending),
        .mem_reqs_pending(mem_reqs_pending)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic load_table;
        // rw, mask, byte enables, lane offset, data base, tag
        rows[0]  = {1'b0, 4'hF, 16'hFFFF, 6'h00, 32'h0000_0000, 8'h10};
        rows[1]  = {1'b1, 4'hF, 16'hFFFF, 6'h00, 32'hCAFE_0100, 8'h11};
        rows[2]  = {1'b0, 4'hF, 16'hFFFF, 6'h00, 32'h0000_0000, 8'h12};
        rows[3]  = {1'b0, 4'h3, 16'hFFFF, 6'h08, 32'h0000_0000, 8'h13};
        rows[4]  = {1'b0, 4'hC, 16'hFFFF, 6'h0C, 32'h0000_0000, 8'h14};
        rows[5]  = {1'b1, 4'h5, 16'hF3FC, 6'h10, 32'h5EED_0000, 8'h15};
        rows[6]  = {1'b0, 4'hF, 16'hFFFF, 6'h10, 32'h0000_0000, 8'h16};
        rows[7]  = {1'b0, 4'h9, 16'hFFFF, 6'h14, 32'h0000_0000, 8'h17};
        rows[8]  = {1'b0, 4'h6, 16'hFFFF, 6'h18, 32'h0000_0000, 8'h18};
        rows[9]  = {1'b0, 4'hF, 16'hFFFF, 6'h20, 32'h0000_0000, 8'h19};
        rows[10] = {1'b1, 4'hA, 16'hFFFF, 6'h20, 32'hBEEF_1000, 8'h1A};
        rows[11] = {1'b0, 4'hF, 16'hFFFF, 6'h20, 32'h0000_0000, 8'h1B};
    endtask

    task automatic send_request(input int row);
        core_req_t req;
        logic      accepted;
        int        waited;
        req.rw     = rows[row].rw;
        req.mask   = rows[row].mask;
        req.byteen = rows[row].byteen;
        req.tag    = rows[row].tag;
        for (int l = 0; l < CORE_REQS; l++) begin
            req.addr[l] = BASE_ADDR + ADDR_WIDTH'(rows[row].offset) + ADDR_WIDTH'(l);
            req.data[l] = rows[row].data + 32'(l);
        end
        core_req       <= req;
        core_req_valid <= 1'b1;
        accepted = 1'b0;
        waited   = 0;
        while (!accepted && waited < WAIT_LIMIT) begin
            @(posedge clk);
            accepted = core_req_ready;
            waited++;
        end
        core_req_valid <= 1'b0;
        if (!accepted) begin
            $display("Timeout: core request with tag %0h was never accepted", rows[row].tag);
            timeouts++;
        end
    endtask

    task automatic wait_for_drain;
        logic drained;
        int   waited;
        drained = 1'b0;
        waited  = 0;
        while (!drained && waited < WAIT_LIMIT) begin
            @(negedge clk);
            drained = reads_pending == 0 && mem_reqs_pending == 0 && core_req_empty;
            waited++;
        end
        if (!drained) begin
            $display("Timeout: reads still unanswered or scheduler not empty after the table");
            timeouts++;
        end
    endtask

    task automatic end_run;
        @(negedge clk);
        $display("Run complete: %0d check errors, %0d timeouts", error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    // Memory model applies writes and captures read data when it takes a request
    task automatic accept_mem_req(input mem_req_t req);
        mem_rsp_t    rsp;
        logic [31:0] word;
        logic [5:0]  idx;
        rsp.mask = req.mask;
        rsp.tag  = req.tag;
        rsp.data = '0;
        for (int c = 0; c < MEM_CHANNELS; c++) begin
            idx  = req.addr[c][5:0];
            word = mem_written[idx] ? mem_words[idx] : {2'b00, req.addr[c]} ^ 32'hA5A5_0000;
            if (req.mask[c] && req.rw) begin
                for (int k = 0; k < WORD_BYTES; k++) begin
                    if (req.byteen[c][k]) begin
                        word[8*k +: 8] = req.data[c][8*k +: 8];
                    end
                end
                mem_words[idx]   = word;
                mem_written[idx] = 1'b1;
            end else if (req.mask[c]) begin
                rsp.data[c] = word;
            end
        end
        if (!req.rw) begin
            pending.push_back(rsp);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
            gap = 0;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                accept_mem_req(mem_req);
            end
            mem_req_ready <= ($random(seed) & 1) != 0;
            // Pick any pending read, so batches come back out of order
            if (!mem_rsp_valid || mem_rsp_ready) begin
                mem_rsp_valid <= 1'b0;
                if (gap > 0) begin
                    gap--;
                end else if (pending.size() > 0) begin
                    pick = $unsigned($random(seed)) % pending.size();
                    mem_rsp       <= pending[pick];
                    mem_rsp_valid <= 1'b1;
                    pending.delete(pick);
                    gap = $unsigned($random(seed)) % 4;
                end
            end
        end
    end

    // Stall the core response long enough to fill every slot
    initial begin
        repeat (14) @(posedge clk);
        core_rsp_ready <= 1'b0;
        repeat (60) @(posedge clk);
        core_rsp_ready <= 1'b1;
    end

    initial begin
        reset          = 1'b1;
        core_req       = '0;
        core_req_valid = 1'b0;
        core_rsp_ready = 1'b1;
        mem_req_ready  = 1'b0;
        mem_rsp        = '0;
        mem_rsp_valid  = 1'b0;
        mem_written    = '0;
        timeouts       = 0;
        load_table();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (timeouts == 0) begin
                send_request(i);
            end
        end
        if (timeouts == 0) begin
            wait_for_drain();
        end
        end_run();
    end

endmodule

/* filelist.f */
common/mem_sched_pkg.sv
request/req_queue.sv
request/req_batcher.sv
response/rsp_assembler.sv
design/slot_table.sv
design/mem_scheduler.sv
tests/mem_sched_checker.sv
tests/tb_mem_scheduler.sv
